// ==== logic/ddr_bridge_pkg.sv ====
`default_nettype none

package ddr_bridge_pkg;

    // application port widths of the DDR3 controller
    localparam int APP_DATA_W = 128;
    localparam int APP_MASK_W = APP_DATA_W / 8;
    localparam int APP_ADDR_W = 29;

    localparam int ID_W = 4;   // host transaction id

    // controller command opcodes
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    // issue FSM
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        READ  = 2'd1,
        WRITE = 2'd2
    } issue_state_e;

    // one queued host command, payload in the low bits
    typedef struct packed {
        logic                  is_read;
        logic                  last;
        logic [ID_W-1:0]       id;
        logic [APP_ADDR_W-1:0] addr;
        logic [APP_DATA_W-1:0] wdata;   // unused on reads
        logic [APP_MASK_W-1:0] wstrb;   // byte enables, active high
    } cmd_entry_t;

endpackage

`default_nettype wire

// ==== logic/rd_beat_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface rd_beat_if;

    logic                                  beat_valid;   // one cycle pulse
    logic [ddr_bridge_pkg::APP_DATA_W-1:0] beat_data;
    logic [ddr_bridge_pkg::ID_W-1:0]       beat_id;
    logic                                  beat_last;
    logic                                  buf_busy;

    // issue FSM side
    modport source (
        output beat_valid,
        output beat_data,
        output beat_id,
        output beat_last,
        input  buf_busy
    );

    // return buffer side
    modport sink (
        input  beat_valid,
        input  beat_data,
        input  beat_id,
        input  beat_last,
        output buf_busy
    );

endinterface

`default_nettype wire

// ==== logic/ddr_cmd_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module ddr_cmd_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  wire                        clk_if,
    input  wire                        resetn,
    input  wire                        push,
    input  wire ddr_bridge_pkg::cmd_entry_t push_entry,
    output logic                       full,
    input  wire                        pop,
    output ddr_bridge_pkg::cmd_entry_t head,
    output logic                       empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

    ddr_bridge_pkg::cmd_entry_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    logic do_push;
    logic do_pop;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];   // valid whenever empty is low

    always_ff @(posedge clk_if) begin
        if (do_push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            count <= '0;
        end else begin
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;   // none, or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ddr_issue_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module ddr_issue_ctrl (
    input  wire                                   clk_if,
    input  wire                                   resetn,

    input  wire ddr_bridge_pkg::cmd_entry_t       head,
    input  wire                                   empty,
    output logic                                  pop,

    output logic                                  app_cmd_en,
    output ddr_bridge_pkg::app_cmd_e              app_cmd,
    output logic [ddr_bridge_pkg::APP_ADDR_W-1:0] app_addr,
    input  wire                                   app_cmd_ready,

    output logic                                  app_wdf_wren,
    output logic                                  app_wdf_end,
    output logic [ddr_bridge_pkg::APP_DATA_W-1:0] app_wdf_data,
    output logic [ddr_bridge_pkg::APP_MASK_W-1:0] app_wdf_mask,
    input  wire                                   app_wdf_rdy,

    input  wire                                   app_rd_data_valid,
    input  wire  [ddr_bridge_pkg::APP_DATA_W-1:0] app_rd_data,

    rd_beat_if.source                             beat
);

    ddr_bridge_pkg::issue_state_e state;
    ddr_bridge_pkg::cmd_entry_t   cur;   // command at the controller

    logic cmd_done;
    logic wdf_done;
    logic rd_hit;

    // one command out at a time, and never while a beat waits for the host
    assign pop = (state == ddr_bridge_pkg::IDLE) && !empty && !beat.buf_busy;

    assign app_cmd      = cur.is_read ? ddr_bridge_pkg::APP_CMD_READ
                                      : ddr_bridge_pkg::APP_CMD_WRITE;
    assign app_addr     = cur.addr;
    assign app_wdf_data = cur.wdata;
    assign app_wdf_mask = ~cur.wstrb;     // controller masks on a set bit
    assign app_wdf_end  = app_wdf_wren;   // single beat writes

    // strobe taken this cycle or already dropped
    assign cmd_done = !app_cmd_en || app_cmd_ready;
    assign wdf_done = !app_wdf_wren || app_wdf_rdy;

    assign rd_hit = (state == ddr_bridge_pkg::READ) && app_rd_data_valid;

    always_ff @(posedge clk_if) begin
        if (pop) begin
            cur <= head;
        end
        if (rd_hit) begin
            beat.beat_data <= app_rd_data;
            beat.beat_id   <= cur.id;
            beat.beat_last <= cur.last;
        end
    end

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            state           <= ddr_bridge_pkg::IDLE;
            app_cmd_en      <= 1'b0;
            app_wdf_wren    <= 1'b0;
            beat.beat_valid <= 1'b0;
        end else begin
            beat.beat_valid <= 1'b0;
            case (state)
                ddr_bridge_pkg::IDLE: begin
                    if (pop) begin
                        app_cmd_en   <= 1'b1;
                        app_wdf_wren <= !head.is_read;
                        state        <= head.is_read ? ddr_bridge_pkg::READ
                                                     : ddr_bridge_pkg::WRITE;
                    end
                end

                ddr_bridge_pkg::READ: begin
                    if (app_cmd_ready) begin
                        app_cmd_en <= 1'b0;
                    end
                    // buffer was free at pop, nothing else fills it
                    if (app_rd_data_valid) begin
                        app_cmd_en      <= 1'b0;
                        beat.beat_valid <= 1'b1;
                        state           <= ddr_bridge_pkg::IDLE;
                    end
                end

                ddr_bridge_pkg::WRITE: begin
                    if (app_cmd_ready) begin
                        app_cmd_en <= 1'b0;
                    end
                    if (app_wdf_rdy) begin
                        app_wdf_wren <= 1'b0;
                    end
                    if (cmd_done && wdf_done) begin
                        state <= ddr_bridge_pkg::IDLE;
                    end
                end

                default: begin
                    app_cmd_en   <= 1'b0;
                    app_wdf_wren <= 1'b0;
                    state        <= ddr_bridge_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/rd_return_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

module rd_return_buf (
    input  wire                                   clk_if,
    input  wire                                   resetn,

    rd_beat_if.sink                               beat,

    output logic                                  rsp_valid,
    output logic [ddr_bridge_pkg::APP_DATA_W-1:0] rsp_data,
    output logic [ddr_bridge_pkg::ID_W-1:0]       rsp_id,
    output logic                                  rsp_last,
    input  wire                                   rsp_ready
);

    logic rsp_take;

    assign rsp_take = rsp_valid && rsp_ready;

    // also busy in the capture cycle, before rsp_valid rises
    assign beat.buf_busy = rsp_valid || beat.beat_valid;

    always_ff @(posedge clk_if) begin
        if (!resetn) begin
            rsp_valid <= 1'b0;
        end else if (beat.beat_valid) begin
            rsp_valid <= 1'b1;
        end else if (rsp_take) begin
            rsp_valid <= 1'b0;
        end
    end

    // fields hold until the host takes the beat
    always_ff @(posedge clk_if) begin
        if (beat.beat_valid) begin
            rsp_data <= beat.beat_data;
            rsp_id   <= beat.beat_id;
            rsp_last <= beat.beat_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ddr_bridge_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ddr_bridge_top #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  wire                                   clk_if,
    input  wire                                   resetn,

    // host commands
    input  wire                                   cmd_valid,
    output logic                                  cmd_ready,
    input  wire                                   cmd_read,
    input  wire  [ddr_bridge_pkg::APP_ADDR_W-1:0] cmd_addr,
    input  wire  [ddr_bridge_pkg::APP_DATA_W-1:0] cmd_wdata,
    input  wire  [ddr_bridge_pkg::APP_MASK_W-1:0] cmd_wstrb,
    input  wire  [ddr_bridge_pkg::ID_W-1:0]       cmd_id,
    input  wire                                   cmd_last,

    // host read responses
    output logic                                  rsp_valid,
    input  wire                                   rsp_ready,
    output logic [ddr_bridge_pkg::APP_DATA_W-1:0] rsp_data,
    output logic [ddr_bridge_pkg::ID_W-1:0]       rsp_id,
    output logic                                  rsp_last,

    // controller application port
    output logic                                  app_cmd_en,
    output ddr_bridge_pkg::app_cmd_e              app_cmd,
    output logic [ddr_bridge_pkg::APP_ADDR_W-1:0] app_addr,
    input  wire                                   app_cmd_ready,
    output logic                                  app_wdf_wren,
    output logic [ddr_bridge_pkg::APP_DATA_W-1:0] app_wdf_data,
    output logic [ddr_bridge_pkg::APP_MASK_W-1:0] app_wdf_mask,
    output logic                                  app_wdf_end,
    input  wire                                   app_wdf_rdy,
    input  wire                                   app_rd_data_valid,
    input  wire  [ddr_bridge_pkg::APP_DATA_W-1:0] app_rd_data,
    input  wire                                   app_rd_data_end
);

    ddr_bridge_pkg::cmd_entry_t push_entry;
    ddr_bridge_pkg::cmd_entry_t head;

    logic full;
    logic empty;
    logic pop;
    logic push;
    logic rd_beat_done;

    rd_beat_if beat_if ();

    assign cmd_ready = !full;
    assign push      = cmd_valid && !full;

    assign push_entry = '{
        is_read: cmd_read,
        last:    cmd_last,
        id:      cmd_id,
        addr:    cmd_addr,
        wdata:   cmd_wdata,
        wstrb:   cmd_wstrb
    };

    // the closing beat of a read completes it
    assign rd_beat_done = app_rd_data_valid && app_rd_data_end;

    ddr_cmd_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue_i (
        .clk_if     (clk_if),
        .resetn     (resetn),
        .push       (push),
        .push_entry (push_entry),
        .full       (full),
        .pop        (pop),
        .head       (head),
        .empty      (empty)
    );

    ddr_issue_ctrl issue_i (
        .clk_if            (clk_if),
        .resetn            (resetn),
        .head              (head),
        .empty             (empty),
        .pop               (pop),
        .app_cmd_en        (app_cmd_en),
        .app_cmd           (app_cmd),
        .app_addr          (app_addr),
        .app_cmd_ready     (app_cmd_ready),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .app_wdf_data      (app_wdf_data),
        .app_wdf_mask      (app_wdf_mask),
        .app_wdf_rdy       (app_wdf_rdy),
        .app_rd_data_valid (rd_beat_done),
        .app_rd_data       (app_rd_data),
        .beat              (beat_if.source)
    );

    rd_return_buf ret_i (
        .clk_if    (clk_if),
        .resetn    (resetn),
        .beat      (beat_if.sink),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_id    (rsp_id),
        .rsp_last  (rsp_last),
        .rsp_ready (rsp_ready)
    );

endmodule

`default_nettype wire

// ==== tests/tb_app_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_app_mem_model (
    input  wire                                   clk_if,
    input  wire                                   resetn,
    input  wire                                   app_cmd_en,
    input  wire ddr_bridge_pkg::app_cmd_e         app_cmd,
    input  wire  [ddr_bridge_pkg::APP_ADDR_W-1:0] app_addr,
    output logic                                  app_cmd_ready,
    input  wire                                   app_wdf_wren,
    input  wire  [ddr_bridge_pkg::APP_DATA_W-1:0] app_wdf_data,
    input  wire  [ddr_bridge_pkg::APP_MASK_W-1:0] app_wdf_mask,
    input  wire                                   app_wdf_end,
    output logic                                  app_wdf_rdy,
    output logic                                  app_rd_data_valid,
    output logic [ddr_bridge_pkg::APP_DATA_W-1:0] app_rd_data,
    output logic                                  app_rd_data_end,
    input  wire                                   cmd_ready_rnd,
    input  wire                                   wdf_rdy_rnd,
    input  wire  [2:0]                            rd_lat,
    output logic [7:0]                            wr_count
);

    localparam int DW = ddr_bridge_pkg::APP_DATA_W;
    localparam int MW = ddr_bridge_pkg::APP_MASK_W;

    logic [DW-1:0] mem [16];   // addr[3:0] window
    logic [3:0]    rd_cnt;
    logic [3:0]    rd_addr;
    logic [3:0]    wr_addr;
    logic [DW-1:0] wr_data;
    logic [MW-1:0] wr_mask;
    logic          wr_cmd_seen;
    logic          wr_dat_seen;
    logic          wr_cmd_now;
    logic          wr_dat_now;
    logic          rd_cmd_now;

    assign app_cmd_ready = cmd_ready_rnd;
    assign app_wdf_rdy   = wdf_rdy_rnd;

    assign wr_cmd_now = app_cmd_en && app_cmd_ready && (app_cmd == ddr_bridge_pkg::APP_CMD_WRITE);
    assign rd_cmd_now = app_cmd_en && app_cmd_ready && (app_cmd == ddr_bridge_pkg::APP_CMD_READ);
    assign wr_dat_now = app_wdf_wren && app_wdf_rdy && app_wdf_end;   // single beat, end required

    // command and data may be taken in either order
    always @(posedge clk_if) begin
        logic [3:0]    a;
        logic [DW-1:0] d;
        logic [MW-1:0] m;
        a = wr_cmd_now ? app_addr[3:0] : wr_addr;
        d = wr_dat_now ? app_wdf_data : wr_data;
        m = wr_dat_now ? app_wdf_mask : wr_mask;
        if (!resetn) begin
            wr_cmd_seen <= 1'b0;
            wr_dat_seen <= 1'b0;
            wr_count    <= '0;
            for (int k = 0; k < 16; k++) begin
                mem[k] <= '0;
            end
        end else begin
            wr_addr <= a;
            wr_data <= d;
            wr_mask <= m;
            if ((wr_cmd_now || wr_cmd_seen) && (wr_dat_now || wr_dat_seen)) begin
                for (int b = 0; b < MW; b++) begin
                    if (!m[b]) begin
                        mem[a][8*b +: 8] <= d[8*b +: 8];   // mask bit set means keep
                    end
                end
                wr_cmd_seen <= 1'b0;
                wr_dat_seen <= 1'b0;
                wr_count    <= wr_count + 1'b1;
            end else begin
                wr_cmd_seen <= wr_cmd_seen || wr_cmd_now;
                wr_dat_seen <= wr_dat_seen || wr_dat_now;
            end
        end
    end

    always @(posedge clk_if) begin
        if (!resetn) begin
            rd_cnt            <= '0;
            app_rd_data_valid <= 1'b0;
            app_rd_data_end   <= 1'b0;
        end else begin
            app_rd_data_valid <= 1'b0;
            app_rd_data_end   <= 1'b0;
            if (rd_cmd_now) begin
                rd_cnt  <= {1'b0, rd_lat} + 4'd1;   // 1 to 8 cycles
                rd_addr <= app_addr[3:0];
            end else if (rd_cnt == 4'd1) begin
                app_rd_data_valid <= 1'b1;
                app_rd_data_end   <= 1'b1;
                app_rd_data       <= mem[rd_addr];
                rd_cnt            <= '0;
            end else if (rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_ddr_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ddr_bridge;

    localparam int DW = ddr_bridge_pkg::APP_DATA_W;
    localparam int QUEUE_DEPTH = 4;

    // written patterns and the merged words they leave
    localparam logic [DW-1:0] D0 = 128'h00112233_44556677_8899aabb_ccddeeff;
    localparam logic [DW-1:0] E0 = 128'h00112233_44556677_5a5a5a5a_ccddeeff;
    localparam logic [DW-1:0] D1 = {4{32'hdeadbeef}};
    localparam logic [DW-1:0] E1 = 128'h00000000_deadbeef_00000000_deadbeef;
    localparam logic [DW-1:0] E3 = {{4{16'hc3c3}}, {4{16'h0303}}};
    localparam logic [DW-1:0] E4 = {64'h0, {4{16'h0404}}};

    typedef struct {
        string                                 name;
        bit                                    rd;
        logic [ddr_bridge_pkg::APP_ADDR_W-1:0] addr;
        logic [DW-1:0]                         wdata;
        logic [ddr_bridge_pkg::APP_MASK_W-1:0] wstrb;
        logic [ddr_bridge_pkg::ID_W-1:0]       id;
        bit                                    last;
        logic [DW-1:0]                         exp;
    } row_t;

    // rows 0-6 basic, 7-12 held response, 13-19 stalled controller
    row_t rows [20] = '{
        '{"wr_full_a0",  0, 0, D0,            16'hffff, 0,  0, 0},
        '{"rd_full_a0",  1, 0, 0,             0,        1,  0, D0},
        '{"wr_part_a0",  0, 0, {16{8'h5a}},   16'h00f0, 0,  0, 0},
        '{"rd_part_a0",  1, 0, 0,             0,        2,  1, E0},
        '{"wr_half_a1",  0, 1, D1,            16'h0f0f, 0,  0, 0},
        '{"rd_half_a1",  1, 1, 0,             0,        3,  0, E1},
        '{"rd_none_a2",  1, 2, 0,             0,        4,  1, 0},
        '{"bp_held_a0",  1, 0, 0,             0,        5,  0, E0},
        '{"bp_q0_a1",    1, 1, 0,             0,        6,  0, E1},
        '{"bp_q1_a2",    1, 2, 0,             0,        7,  1, 0},
        '{"bp_q2_a0",    1, 0, 0,             0,        8,  0, E0},
        '{"bp_q3_a1",    1, 1, 0,             0,        9,  1, E1},
        '{"bp_probe_a2", 1, 2, 0,             0,        10, 0, 0},
        '{"st_wr_a3",    0, 3, {8{16'h0303}}, 16'hffff, 0,  0, 0},
        '{"st_wr_hi_a3", 0, 3, {8{16'hc3c3}}, 16'hff00, 0,  0, 0},
        '{"st_wr_lo_a4", 0, 4, {8{16'h0404}}, 16'h00ff, 0,  0, 0},
        '{"sweep_a0",    1, 0, 0,             0,        11, 0, E0},
        '{"sweep_a1",    1, 1, 0,             0,        12, 0, E1},
        '{"sweep_a3",    1, 3, 0,             0,        13, 0, E3},
        '{"sweep_a4",    1, 4, 0,             0,        14, 1, E4}
    };

    logic clk_if;
    logic resetn;
    logic cmd_valid, cmd_ready, cmd_read, cmd_last;
    logic [ddr_bridge_pkg::APP_ADDR_W-1:0] cmd_addr;
    logic [DW-1:0]                         cmd_wdata;
    logic [ddr_bridge_pkg::APP_MASK_W-1:0] cmd_wstrb;
    logic [ddr_bridge_pkg::ID_W-1:0]       cmd_id;
    logic rsp_valid, rsp_ready, rsp_last;
    logic [DW-1:0]                         rsp_data;
    logic [ddr_bridge_pkg::ID_W-1:0]       rsp_id;
    logic app_cmd_en, app_cmd_ready, app_wdf_wren, app_wdf_end, app_wdf_rdy;
    ddr_bridge_pkg::app_cmd_e              app_cmd;
    logic [ddr_bridge_pkg::APP_ADDR_W-1:0] app_addr;
    logic [DW-1:0]                         app_wdf_data;
    logic [ddr_bridge_pkg::APP_MASK_W-1:0] app_wdf_mask;
    logic app_rd_data_valid, app_rd_data_end;
    logic [DW-1:0]                         app_rd_data;
    logic cmd_ready_rnd, wdf_rdy_rnd;
    logic [2:0] rd_lat;
    logic [7:0] wr_count;

    logic [31:0] lfsr = 32'h445abf64;
    logic hold_rsp;
    logic stall_en;
    int mism_errs;
    int misc_errs;
    int wr_sent;
    int exp_q [$];   // row index of each outstanding read
    int wr_q [$];

    ddr_bridge_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut_i (.*);

    tb_app_mem_model mem_i (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic expect_eq(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
            mism_errs++;
        end
    endtask

    // called just after a rising edge, returns just after one
    task automatic send_row(input int i, input int max_wait, input bit must, output bit taken);
        int n;
        n = 0;
        taken = 1'b0;
        cmd_valid = 1'b1;
        cmd_read  = rows[i].rd;
        cmd_addr  = rows[i].addr;
        cmd_wdata = rows[i].wdata;
        cmd_wstrb = rows[i].wstrb;
        cmd_id    = rows[i].id;
        cmd_last  = rows[i].last;
        while (!taken && n < max_wait) begin
            @(negedge clk_if);
            taken = cmd_ready;
            @(posedge clk_if);
            #2;
            n++;
        end
        cmd_valid = 1'b0;
        if (taken && rows[i].rd) begin
            exp_q.push_back(i);
        end else if (taken) begin
            wr_q.push_back(i);
            wr_sent++;
        end
        if (must && !taken) begin
            $display("Error: %s not accepted within %0d cycles", rows[i].name, max_wait);
            misc_errs++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            @(posedge clk_if);
            n++;
        end while ((exp_q.size() != 0 || wr_q.size() != 0) && n < 1000);
        if (exp_q.size() != 0 || wr_q.size() != 0) begin
            $display("Error: timed out with %0d reads and %0d writes outstanding",
                     exp_q.size(), wr_q.size());
            misc_errs++;
        end
        #2;
    endtask

    initial begin
        clk_if = 1'b0;
        forever #10 clk_if = ~clk_if;
    end

    // all random knobs from one process, so the sequence is fixed
    always @(posedge clk_if) begin
        logic [7:0] r;
        #2;
        take_bits(2, r);
        cmd_ready_rnd = !stall_en || (r[1:0] != 2'b00);
        take_bits(2, r);
        wdf_rdy_rnd = !stall_en || (r[1:0] != 2'b00);
        take_bits(3, r);
        rd_lat = r[2:0];
        take_bits(2, r);
        rsp_ready = !hold_rsp && (r[1:0] != 2'b00);
    end

    always @(negedge clk_if) begin
        int i;
        logic [ddr_bridge_pkg::APP_MASK_W-1:0] mask;
        if (rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error: read response arrived with no read outstanding");
                misc_errs++;
            end else begin
                i = exp_q.pop_front();
                expect_eq({rows[i].name, " data"}, rows[i].exp, rsp_data);
                expect_eq({rows[i].name, " id"}, rows[i].id, rsp_id);
                expect_eq({rows[i].name, " last"}, rows[i].last, rsp_last);
            end
        end
        if (app_wdf_wren && app_wdf_rdy) begin
            if (wr_q.size() == 0) begin
                $display("Error: write data sent with no write outstanding");
                misc_errs++;
            end else begin
                i = wr_q.pop_front();
                mask = ~rows[i].wstrb;
                expect_eq({rows[i].name, " mask"}, mask, app_wdf_mask);
                expect_eq({rows[i].name, " wdf_end"}, 1, app_wdf_end);
            end
        end
    end

    initial begin
        bit taken;
        int acc;
        int n;
        resetn = 1'b0;
        cmd_valid = 1'b0;
        cmd_read = 1'b0;
        cmd_addr = '0;
        cmd_wdata = '0;
        cmd_wstrb = '0;
        cmd_id = '0;
        cmd_last = 1'b0;
        rsp_ready = 1'b0;
        cmd_ready_rnd = 1'b1;
        wdf_rdy_rnd = 1'b1;
        rd_lat = 3'd0;
        hold_rsp = 1'b0;
        stall_en = 1'b0;
        mism_errs = 0;
        misc_errs = 0;
        wr_sent = 0;
        repeat (8) @(posedge clk_if);
        #2 resetn = 1'b1;
        @(negedge clk_if);
        expect_eq("reset cmd_ready", 1, cmd_ready);
        expect_eq("reset rsp_valid", 0, rsp_valid);
        expect_eq("reset app_cmd_en", 0, app_cmd_en);
        expect_eq("reset app_wdf_wren", 0, app_wdf_wren);
        @(posedge clk_if);
        #2;
        for (int i = 0; i < 7; i++) begin
            send_row(i, 200, 1'b1, taken);
        end
        wait_drain();

        // host stops taking responses, queue fills behind the held beat
        @(negedge clk_if);
        hold_rsp = 1'b1;
        @(posedge clk_if);
        #2;
        send_row(7, 200, 1'b1, taken);
        n = 0;
        while (!rsp_valid && n < 100) begin
            @(negedge clk_if);
            n++;
        end
        if (!rsp_valid) begin
            $display("Error: held read response never became valid");
            misc_errs++;
        end
        @(posedge clk_if);
        #2;
        acc = 0;
        taken = 1'b1;
        for (int i = 8; i < 13 && taken; i++) begin
            send_row(i, 20, 1'b0, taken);
            acc += taken;
        end
        @(negedge clk_if);
        expect_eq("bp cmd_ready", 0, cmd_ready);
        if (acc > QUEUE_DEPTH) begin
            $display("Error: %0d commands accepted behind a held response", acc);
            misc_errs++;
        end
        hold_rsp = 1'b0;
        wait_drain();

        @(negedge clk_if);
        stall_en = 1'b1;   // random controller ready stalls
        @(posedge clk_if);
        #2;
        for (int i = 13; i < 20; i++) begin
            send_row(i, 200, 1'b1, taken);
        end
        wait_drain();
        expect_eq("write count", wr_sent, wr_count);

        $display("errors: %0d mismatches, %0d other", mism_errs, misc_errs);
        if (mism_errs + misc_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/ddr_bridge_pkg.sv
logic/rd_beat_if.sv
logic/ddr_cmd_queue.sv
logic/ddr_issue_ctrl.sv
logic/rd_return_buf.sv
logic/ddr_bridge_top.sv
tests/tb_app_mem_model.sv
tests/tb_ddr_bridge.sv

// ==== Bender.yml ====
package:
  name: ddr_bridge

sources:
  - logic/ddr_bridge_pkg.sv
  - logic/rd_beat_if.sv
  - logic/ddr_cmd_queue.sv
  - logic/ddr_issue_ctrl.sv
  - logic/rd_return_buf.sv
  - logic/ddr_bridge_top.sv
  - target: test
    files:
      - tests/tb_app_mem_model.sv
      - tests/tb_ddr_bridge.sv
